//--- logic/decode_opnd_signals.sv
module decode_opnd_signals
  import x86_decode_pkg::*;
(
  input  logic [71:0]   unescaped,
  input  opnd_form_e    form,
  input  logic          addr16,
  output opnd_signals_t sig
);

  logic [15:0] form_1hot;
  logic [7:0]  modrm;
  logic [7:0]  sib;
  logic [1:0]  mod;
  logic [2:0]  rm;
  logic        reg_direct;
  logic        op0_rm;
  logic        op0_reg;
  logic        op1_rm;
  logic        op1_reg;
  logic        has_modrm;
  logic        has_sib;
  logic        has_imm;
  logic        disp_only;
  logic        sib_base_disp;
  logic        has_disp;

  // One bit per form keeps the role terms flat
  assign form_1hot = 16'b1 << form;

  // Forms that carry immediate bytes
  assign has_imm = form_1hot[FORM_IMM] || form_1hot[FORM_REG_IMM] ||
                   form_1hot[FORM_EAX_IMM] || form_1hot[FORM_RM_IMM] ||
                   form_1hot[FORM_REG_RM_IMM] || form_1hot[FORM_RM_REG_IMM];

  // R/M field is the first operand, direction bit clear
  assign op0_rm = form_1hot[FORM_RM] || form_1hot[FORM_RM_IMM] ||
                  form_1hot[FORM_RM_REG] || form_1hot[FORM_RM_REG_IMM] ||
                  form_1hot[FORM_RM_REG_CL];

  // Reg field is the first operand, direction bit set
  assign op0_reg = form_1hot[FORM_REG_RM] || form_1hot[FORM_REG_RM_IMM];

  // Second slot mirrors the first
  assign op1_rm  = op0_reg;
  assign op1_reg = form_1hot[FORM_RM_REG] || form_1hot[FORM_RM_REG_IMM] ||
                   form_1hot[FORM_RM_REG_CL];

  assign has_modrm = op0_rm || op0_reg;

  // ModR/M follows the opcode, SIB follows ModR/M
  assign modrm = unescaped[15:8];
  assign sib   = unescaped[23:16];
  assign mod   = modrm[7:6];
  assign rm    = modrm[2:0];

  assign reg_direct = (mod == 2'b11);

  // SIB only exists in 32-bit addressing with rm 100 and a memory operand
  assign has_sib = has_modrm && !addr16 && !reg_direct && (rm == 3'b100);

  // Absolute address: rm 110 in 16-bit mode, rm 101 in 32-bit mode
  assign disp_only = (mod == 2'b00) && (rm == (addr16 ? 3'b110 : 3'b101));

  // SIB with base 101 and mod 00 also takes disp32
  assign sib_base_disp = has_sib && (mod == 2'b00) && (sib[2:0] == 3'b101);

  // Memory displacement, or the relative offset of a jump
  assign has_disp = (has_modrm && !reg_direct &&
                     (mod == 2'b01 || mod == 2'b10 || disp_only || sib_base_disp)) ||
                    form_1hot[FORM_DISP];

  always_comb begin
    sig.has_modrm        = has_modrm;
    sig.has_sib          = has_sib;
    sig.has_disp         = has_disp;
    sig.has_imm          = has_imm;
    sig.modrm            = modrm;
    sig.sib              = sib;
    sig.rm_is_reg_direct = reg_direct;
    sig.op0_rm           = op0_rm;
    sig.op0_reg          = op0_reg;
    sig.op1_rm           = op1_rm;
    sig.op1_reg          = op1_reg;
  end

endmodule

//--- logic/instr_fetch_wb.sv
module instr_fetch_wb
  import x86_decode_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      go,
  input  logic [31:0]               start_pc,
  input  logic                      advance,
  input  logic [3:0]                advance_len,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output logic [31:0]               wb_adr,
  input  logic [31:0]               wb_dat_rd,
  input  logic                      wb_ack,
  output logic [8*WINDOW_BYTES-1:0] window,
  output logic [31:0]               window_pc,
  output logic                      window_valid
);

  fetch_state_e                 state;
  logic [31:0]                  pc;
  logic [31:0]                  buf_base;
  logic                         buf_valid;
  logic [$clog2(BUF_WORDS)-1:0] word_idx;
  logic [31:0]                  buf_words [BUF_WORDS];
  logic [32*BUF_WORDS-1:0]      buf_flat;
  logic [32*BUF_WORDS-1:0]      buf_shift;
  logic [31:0]                  pc_offset;
  logic                         hit;

  // Distance of the PC from the buffer base, wraps huge when PC lies below it
  assign pc_offset = pc - buf_base;
  // Whole window PC..PC+11 must sit inside the 16 buffered bytes
  assign hit = buf_valid && (pc_offset <= 32'(4 * BUF_WORDS - WINDOW_BYTES));

  // Little-endian byte order, word 0 in the low bits
  always_comb begin
    for (int i = 0; i < BUF_WORDS; i++) begin
      buf_flat[32*i +: 32] = buf_words[i];
    end
  end

  // Byte shift so that window byte 0 is the byte at PC
  assign buf_shift = buf_flat >> {pc_offset[2:0], 3'b000};
  assign window    = buf_shift[8*WINDOW_BYTES-1:0];
  assign window_pc = pc;

  // Window is only offered while waiting to be decoded
  assign window_valid = (state == FETCH_DECODE) && hit;

  // Classic read master, stb follows cyc and writes never happen
  assign wb_stb = wb_cyc;
  assign wb_we  = 1'b0;
  assign wb_adr = buf_base + (32'(word_idx) << 2);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= FETCH_IDLE;
      pc        <= '0;
      buf_base  <= '0;
      buf_valid <= 1'b0;
      word_idx  <= '0;
      wb_cyc    <= 1'b0;
    end else begin
      unique case (state)
        FETCH_IDLE: begin
          // Start address is taken once, on go
          if (go) begin
            pc    <= start_pc;
            state <= FETCH_DECODE;
          end
        end
        FETCH_DECODE: begin
          if (hit) begin
            state <= FETCH_HOLD;
          end else begin
            // Refill from the word holding the PC
            buf_base  <= {pc[31:2], 2'b00};
            buf_valid <= 1'b0;
            word_idx  <= '0;
            wb_cyc    <= 1'b1;
            state     <= FETCH_BUS;
          end
        end
        FETCH_BUS: begin
          if (wb_cyc && wb_ack) begin
            // Bus goes idle for one cycle after every word
            wb_cyc   <= 1'b0;
            word_idx <= word_idx + 1'b1;
            if (word_idx == $bits(word_idx)'(BUF_WORDS - 1)) begin
              buf_valid <= 1'b1;
              state     <= FETCH_DECODE;
            end
          end else if (!wb_cyc) begin
            wb_cyc <= 1'b1;
          end
        end
        FETCH_HOLD: begin
          // Record sits in the output register until accepted
          if (advance) begin
            pc    <= pc + 32'(advance_len);
            state <= FETCH_DECODE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Buffer storage, written once per acked word
  always_ff @(posedge clk) begin
    if (state == FETCH_BUS && wb_cyc && wb_ack) begin
      buf_words[word_idx] <= wb_dat_rd;
    end
  end

endmodule

//--- logic/instr_length_calc.sv
module instr_length_calc
  import x86_decode_pkg::*;
(
  input  prefix_info_t  info,
  input  opnd_signals_t sig,
  input  size_class_e   imm_class,
  input  size_class_e   rel_class,
  output logic [2:0]    disp_len,
  output logic [2:0]    imm_len,
  output logic [3:0]    length,
  output logic          too_long
);

  logic [1:0] mod;
  logic [4:0] total;

  // Bytes for a size class, Z shrinks to a word under 0x66
  function automatic logic [2:0] size_bytes(input size_class_e c, input logic o16);
    case (c)
      SZ_BYTE: size_bytes = 3'd1;
      SZ_Z:    size_bytes = o16 ? 3'd2 : 3'd4;
      default: size_bytes = 3'd0;
    endcase
  endfunction

  assign mod = sig.modrm[7:6];

  always_comb begin
    disp_len = 3'd0;
    if (rel_class != SZ_NONE) begin
      // Jump offset
      disp_len = size_bytes(rel_class, info.opsize16);
    end else if (sig.has_disp) begin
      if (mod == 2'b01) begin
        disp_len = 3'd1;
      end else if (info.addr16) begin
        // mod 10, or mod 00 with rm 110
        disp_len = 3'd2;
      end else begin
        // mod 10, rm 101, or SIB base 101
        disp_len = 3'd4;
      end
    end
  end

  assign imm_len = size_bytes(imm_class, info.opsize16);

  // Prefixes, escape, opcode, ModR/M, SIB, displacement, immediate
  assign total = 5'(info.count) + 5'(info.escaped) + 5'd1 +
                 5'(sig.has_modrm) + 5'(sig.has_sib) + 5'(disp_len) + 5'(imm_len);

  assign length   = total[3:0];
  assign too_long = (total > 5'(WINDOW_BYTES));

endmodule

//--- logic/opcode_form_lookup.sv
module opcode_form_lookup
  import x86_decode_pkg::*;
(
  input  prefix_info_t info,
  output opnd_form_e   form,
  output size_class_e  imm_class,
  output size_class_e  rel_class
);

  // Escape bit in front of the opcode keeps both maps in one table
  logic [8:0] key;

  assign key = {info.escaped, info.opcode};

  always_comb begin
    form      = FORM_INVALID;
    imm_class = SZ_NONE;
    rel_class = SZ_NONE;
    casez (key)
      // NOP
      9'h090: form = FORM_NONE;
      // PUSH imm8
      9'h06A: begin
        form      = FORM_IMM;
        imm_class = SZ_BYTE;
      end
      // ADD AL, imm8
      9'h004: begin
        form      = FORM_EAX_IMM;
        imm_class = SZ_BYTE;
      end
      // ADD eAX, imm
      9'h005: begin
        form      = FORM_EAX_IMM;
        imm_class = SZ_Z;
      end
      // MOV r, imm with the register in the low opcode bits
      9'b0_1011_1???: begin
        form      = FORM_REG_IMM;
        imm_class = SZ_Z;
      end
      // MOV r/m, r in byte and full size
      9'b0_1000_100?: form = FORM_RM_REG;
      // MOV r, r/m
      9'b0_1000_101?: form = FORM_REG_RM;
      // MOV r/m, imm
      9'h0C7: begin
        form      = FORM_RM_IMM;
        imm_class = SZ_Z;
      end
      // IMUL r, r/m, imm8
      9'h06B: begin
        form      = FORM_REG_RM_IMM;
        imm_class = SZ_BYTE;
      end
      // Group 5, sub-op in ModR/M.reg
      9'h0FF: form = FORM_RM;
      // Short and near relative jumps
      9'h0EB: begin
        form      = FORM_DISP;
        rel_class = SZ_BYTE;
      end
      9'h0E9: begin
        form      = FORM_DISP;
        rel_class = SZ_Z;
      end
      // SHLD r/m, r, imm8
      9'h1A4: begin
        form      = FORM_RM_REG_IMM;
        imm_class = SZ_BYTE;
      end
      // SHLD r/m, r, CL
      9'h1A5: form = FORM_RM_REG_CL;
      default: form = FORM_INVALID;
    endcase
  end

endmodule

//--- logic/prefix_scanner.sv
module prefix_scanner
  import x86_decode_pkg::*;
(
  input  logic [8*WINDOW_BYTES-1:0] window,
  output prefix_info_t              info,
  output logic [71:0]               unescaped
);

  logic                      run;
  logic [1:0]                count;
  logic                      opsize16;
  logic                      addr16;
  logic [7:0]                first_byte;
  logic                      escaped;
  logic [2:0]                op_pos;
  logic [8*WINDOW_BYTES-1:0] op_shift;

  // Legacy prefixes: size overrides, lock, rep and the segment overrides
  function automatic logic is_prefix(input logic [7:0] b);
    case (b)
      8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3: is_prefix = 1'b1;
      8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: is_prefix = 1'b1;
      default: is_prefix = 1'b0;
    endcase
  endfunction

  // Count leading prefixes, stop at the first byte that is not one
  always_comb begin
    run      = 1'b1;
    count    = '0;
    opsize16 = 1'b0;
    addr16   = 1'b0;
    for (int i = 0; i < MAX_PREFIX; i++) begin
      if (run && is_prefix(window[8*i +: 8])) begin
        count = count + 1'b1;
        if (window[8*i +: 8] == 8'h66) opsize16 = 1'b1;
        if (window[8*i +: 8] == 8'h67) addr16 = 1'b1;
      end else begin
        run = 1'b0;
      end
    end
  end

  // Byte after the prefixes, maybe the two-byte escape
  assign first_byte = window[{count, 3'b000} +: 8];
  assign escaped    = (first_byte == 8'h0F);
  assign op_pos     = {1'b0, count} + {2'b00, escaped};

  // Opcode lands in byte 0, bytes past the window read as zero
  assign op_shift  = window >> {op_pos, 3'b000};
  assign unescaped = op_shift[71:0];

  always_comb begin
    info.count    = count;
    info.opsize16 = opsize16;
    info.addr16   = addr16;
    info.escaped  = escaped;
    info.opcode   = unescaped[7:0];
  end

endmodule

//--- logic/x86_decode_pkg.sv
package x86_decode_pkg;

  // Bytes handed from the fetch buffer to the decode chain
  localparam int WINDOW_BYTES = 12;
  // Words read per Wishbone refill
  localparam int BUF_WORDS    = 4;
  // Legacy prefixes accepted ahead of the opcode
  localparam int MAX_PREFIX   = 3;

  // Operand layout of an instruction
  typedef enum logic [3:0] {
    FORM_NONE,
    FORM_IMM,
    FORM_DISP,
    FORM_REG_IMM,
    FORM_EAX_IMM,
    FORM_RM,
    FORM_RM_IMM,
    FORM_RM_REG,
    FORM_REG_RM,
    FORM_REG_RM_IMM,
    FORM_RM_REG_IMM,
    FORM_RM_REG_CL,
    FORM_INVALID
  } opnd_form_e;

  // SZ_Z is 4 bytes, or 2 under the operand-size override
  typedef enum logic [1:0] {
    SZ_NONE,
    SZ_BYTE,
    SZ_Z
  } size_class_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_BUS,
    FETCH_DECODE,
    FETCH_HOLD
  } fetch_state_e;

  // Result of the prefix scan
  typedef struct packed {
    logic [1:0] count;
    logic       opsize16;
    logic       addr16;
    logic       escaped;
    logic [7:0] opcode;
  } prefix_info_t;

  // Operand bytes and slot roles taken from ModR/M
  typedef struct packed {
    logic       has_modrm;
    logic       has_sib;
    logic       has_disp;
    logic       has_imm;
    logic [7:0] modrm;
    logic [7:0] sib;
    logic       rm_is_reg_direct;
    logic       op0_rm;
    logic       op0_reg;
    logic       op1_rm;
    logic       op1_reg;
  } opnd_signals_t;

  // One record per instruction on the output handshake
  typedef struct packed {
    logic [31:0]   pc;
    logic [3:0]    length;
    opnd_form_e    form;
    opnd_signals_t sig;
    logic [2:0]    disp_len;
    logic [2:0]    imm_len;
    logic          invalid;
  } decoded_instr_t;

endpackage

//--- logic/x86_decode_top.sv
module x86_decode_top
  import x86_decode_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           go,
  input  logic [31:0]    start_pc,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output logic [31:0]    wb_adr,
  input  logic [31:0]    wb_dat_rd,
  input  logic           wb_ack,
  output logic           out_valid,
  input  logic           out_ready,
  output decoded_instr_t out_instr
);

  logic [8*WINDOW_BYTES-1:0] window;
  logic [31:0]               window_pc;
  logic                      window_valid;
  logic                      advance;
  logic [3:0]                advance_len;
  prefix_info_t              info;
  logic [71:0]               unescaped;
  opnd_form_e                form;
  size_class_e               imm_class;
  size_class_e               rel_class;
  opnd_signals_t             sig;
  logic [2:0]                disp_len;
  logic [2:0]                imm_len;
  logic [3:0]                length;
  logic                      too_long;
  decoded_instr_t            record;

  // PC moves on the accepted transfer, a bad opcode skips one byte
  assign advance     = out_valid && out_ready;
  assign advance_len = out_instr.invalid ? 4'd1 : out_instr.length;

  instr_fetch_wb u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .go           (go),
    .start_pc     (start_pc),
    .advance      (advance),
    .advance_len  (advance_len),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_rd    (wb_dat_rd),
    .wb_ack       (wb_ack),
    .window       (window),
    .window_pc    (window_pc),
    .window_valid (window_valid)
  );

  prefix_scanner u_prefix (
    .window    (window),
    .info      (info),
    .unescaped (unescaped)
  );

  opcode_form_lookup u_lookup (
    .info      (info),
    .form      (form),
    .imm_class (imm_class),
    .rel_class (rel_class)
  );

  decode_opnd_signals u_opnd (
    .unescaped (unescaped),
    .form      (form),
    .addr16    (info.addr16),
    .sig       (sig)
  );

  instr_length_calc u_length (
    .info      (info),
    .sig       (sig),
    .imm_class (imm_class),
    .rel_class (rel_class),
    .disp_len  (disp_len),
    .imm_len   (imm_len),
    .length    (length),
    .too_long  (too_long)
  );

  // Record assembled from the combinational chain
  always_comb begin
    record.pc       = window_pc;
    record.length   = length;
    record.form     = form;
    record.sig      = sig;
    record.disp_len = disp_len;
    record.imm_len  = imm_len;
    record.invalid  = (form == FORM_INVALID) || too_long;
  end

  // Fetch offers a window only after the previous record has left
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (window_valid) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload is held while ready is low
  always_ff @(posedge clk) begin
    if (window_valid) begin
      out_instr <= record;
    end
  end

endmodule

//--- tb.f
logic/x86_decode_pkg.sv
logic/instr_fetch_wb.sv
logic/prefix_scanner.sv
logic/opcode_form_lookup.sv
logic/decode_opnd_signals.sv
logic/instr_length_calc.sv
logic/x86_decode_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_mem.sv
testbench/tb_x86_decode.sv

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release lands on a falling edge, away from the DUT sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- testbench/tb_wb_mem.sv
module tb_wb_mem #(
  parameter int WORDS = 512,
  parameter int SEED  = 54
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  output logic [31:0] wb_dat_rd,
  output logic        wb_ack
);

  localparam int AW = $clog2(WORDS);

  // Filled by the testbench before the first fetch
  logic [31:0] mem [WORDS];
  integer      seed;
  int          wait_left;

  initial begin
    seed      = SEED;
    wb_ack    = 1'b0;
    wb_dat_rd = '0;
    wait_left = 0;
  end

  // Slave outputs change on the falling edge, master samples on the rising one
  always @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack    <= 1'b0;
      wb_dat_rd <= '0;
      wait_left <= 0;
    end else if (wb_ack) begin
      // Single-cycle ack, then pick the wait for the next word
      wb_ack    <= 1'b0;
      wait_left <= $unsigned($random(seed)) % 4;
    end else if (wb_cyc && wb_stb && !wb_we) begin
      if (wait_left == 0) begin
        wb_ack    <= 1'b1;
        wb_dat_rd <= mem[wb_adr[AW+1:2]];
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

//--- testbench/tb_x86_decode.sv
module tb_x86_decode
  import x86_decode_pkg::*;
();

  localparam logic [31:0] START_PC   = 32'h0000_0103;
  localparam int          MEM_BYTES  = 2048;
  localparam int          NUM_INSTR  = 80;
  localparam int          WAIT_LIMIT = 200;

  logic           clk;
  logic           arst_n;
  logic           go;
  logic [31:0]    start_pc;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic [31:0]    wb_adr;
  logic [31:0]    wb_dat_rd;
  logic           wb_ack;
  logic           out_valid;
  logic           out_ready;
  decoded_instr_t out_instr;

  // Byte image of the memory that the reference model also reads
  logic [7:0] mem_bytes [MEM_BYTES];
  integer     seed = 54;
  int         errors = 0;

  tb_clock_gen u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  tb_wb_mem #(.WORDS(MEM_BYTES / 4), .SEED(54)) u_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_rd (wb_dat_rd),
    .wb_ack    (wb_ack)
  );

  x86_decode_top u_x86_decode_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (go),
    .start_pc  (start_pc),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_rd (wb_dat_rd),
    .wb_ack    (wb_ack),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_instr (out_instr)
  );

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic legacy_prefix(input logic [7:0] b);
    case (b)
      8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3: return 1'b1;
      // Segment overrides
      8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] prefix_byte(input int i);
    case (i)
      0: return 8'h66;
      1: return 8'h67;
      2: return 8'h2E;
      default: return 8'hF3;
    endcase
  endfunction

  // Stimulus opcodes with 0F in the high byte for the two-byte map
  function automatic logic [15:0] opcode_entry(input int i);
    case (i)
      0: return 16'h0090;
      1: return 16'h006A;
      2: return 16'h0004;
      3: return 16'h0005;
      4: return 16'h00B8;
      5: return 16'h0088;
      6: return 16'h008A;
      7: return 16'h00C7;
      8: return 16'h006B;
      9: return 16'h00FF;
      10: return 16'h00EB;
      11: return 16'h00E9;
      12: return 16'h0FA4;
      13: return 16'h0FA5;
      // HLT and UD2 are outside the supported subset
      14: return 16'h00F4;
      default: return 16'h0F0B;
    endcase
  endfunction

  // Reference decode of the bytes at pc
  function automatic decoded_instr_t expected_at(input logic [31:0] pc);
    logic [7:0]     b [WINDOW_BYTES];
    int             count;
    int             z;
    int             imm;
    int             disp;
    int             total;
    logic           scanning;
    logic           o16;
    logic           a16;
    logic           esc;
    logic [7:0]     op;
    logic [7:0]     m;
    logic [7:0]     s;
    opnd_form_e     form;
    decoded_instr_t r;
    r        = '0;
    count    = 0;
    scanning = 1'b1;
    o16      = 1'b0;
    a16      = 1'b0;
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      b[i] = mem_bytes[int'(pc) + i];
    end
    for (int i = 0; i < MAX_PREFIX; i++) begin
      if (scanning && legacy_prefix(b[i])) begin
        count++;
        if (b[i] == 8'h66) o16 = 1'b1;
        if (b[i] == 8'h67) a16 = 1'b1;
      end else begin
        scanning = 1'b0;
      end
    end
    esc  = (b[count] == 8'h0F);
    op   = b[count + esc];
    m    = b[count + esc + 1];
    s    = b[count + esc + 2];
    z    = o16 ? 2 : 4;
    imm  = 0;
    disp = 0;
    form = FORM_INVALID;
    casez ({esc, op})
      9'h090: form = FORM_NONE;
      9'h06A: begin
        form = FORM_IMM;
        imm  = 1;
      end
      9'h004: begin
        form = FORM_EAX_IMM;
        imm  = 1;
      end
      9'h005: begin
        form = FORM_EAX_IMM;
        imm  = z;
      end
      9'b0_1011_1???: begin
        form = FORM_REG_IMM;
        imm  = z;
      end
      9'b0_1000_100?: form = FORM_RM_REG;
      9'b0_1000_101?: form = FORM_REG_RM;
      9'h0C7: begin
        form = FORM_RM_IMM;
        imm  = z;
      end
      9'h06B: begin
        form = FORM_REG_RM_IMM;
        imm  = 1;
      end
      9'h0FF: form = FORM_RM;
      9'h0EB: begin
        form = FORM_DISP;
        disp = 1;
      end
      9'h0E9: begin
        form = FORM_DISP;
        disp = z;
      end
      9'h1A4: begin
        form = FORM_RM_REG_IMM;
        imm  = 1;
      end
      9'h1A5: form = FORM_RM_REG_CL;
      default: form = FORM_INVALID;
    endcase
    // Slot roles follow the operand order in the form name
    r.sig.op0_rm  = (form == FORM_RM) || (form == FORM_RM_IMM) || (form == FORM_RM_REG) ||
                    (form == FORM_RM_REG_IMM) || (form == FORM_RM_REG_CL);
    r.sig.op0_reg = (form == FORM_REG_RM) || (form == FORM_REG_RM_IMM);
    r.sig.op1_rm  = (form == FORM_REG_RM) || (form == FORM_REG_RM_IMM);
    r.sig.op1_reg = (form == FORM_RM_REG) || (form == FORM_RM_REG_IMM) ||
                    (form == FORM_RM_REG_CL);
    r.sig.has_modrm        = r.sig.op0_rm || r.sig.op0_reg;
    r.sig.rm_is_reg_direct = (m[7:6] == 2'b11);
    r.sig.has_sib = r.sig.has_modrm && !a16 && (m[7:6] != 2'b11) && (m[2:0] == 3'b100);
    if (r.sig.has_modrm && m[7:6] == 2'b01) begin
      disp = 1;
    end else if (r.sig.has_modrm && a16) begin
      if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && m[2:0] == 3'b110)) disp = 2;
    end else if (r.sig.has_modrm) begin
      if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && m[2:0] == 3'b101)) disp = 4;
      // SIB with no base register
      if (r.sig.has_sib && m[7:6] == 2'b00 && s[2:0] == 3'b101) disp = 4;
    end
    total = count + esc + 1 + r.sig.has_modrm + r.sig.has_sib + disp + imm;
    r.pc          = pc;
    r.length      = 4'(total);
    r.form        = form;
    r.sig.has_disp = (disp != 0);
    r.sig.has_imm  = (imm != 0);
    r.sig.modrm    = m;
    r.sig.sib      = s;
    r.disp_len     = 3'(disp);
    r.imm_len      = 3'(imm);
    r.invalid      = (form == FORM_INVALID) || (total > WINDOW_BYTES);
    return r;
  endfunction

  task automatic report_mismatch(input string test, input logic [127:0] exp,
                                 input logic [127:0] act);
    errors++;
    $display("FAIL %s expected %0h actual %0h", test, exp, act);
    $display("Test failures found");
    $fatal(1, "%s mismatch", test);
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("Test failures found");
    $fatal(1, "%s", what);
  endtask

  task automatic check_equal(input string test, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp) else report_mismatch(test, exp, act);
  endtask

  task automatic check_record(input decoded_instr_t e);
    check_equal("pc_chain", e.pc, out_instr.pc);
    check_equal("form", e.form, out_instr.form);
    check_equal("modrm_roles",
                {e.sig.has_modrm, e.sig.op0_rm, e.sig.op0_reg, e.sig.op1_rm,
                 e.sig.op1_reg, e.sig.has_imm},
                {out_instr.sig.has_modrm, out_instr.sig.op0_rm, out_instr.sig.op0_reg,
                 out_instr.sig.op1_rm, out_instr.sig.op1_reg, out_instr.sig.has_imm});
    check_equal("sib_disp",
                {e.sig.has_sib, e.sig.has_disp, e.sig.rm_is_reg_direct, e.disp_len},
                {out_instr.sig.has_sib, out_instr.sig.has_disp,
                 out_instr.sig.rm_is_reg_direct, out_instr.disp_len});
    check_equal("imm_length", {e.imm_len, e.length}, {out_instr.imm_len, out_instr.length});
    check_equal("invalid", e.invalid, out_instr.invalid);
    // Whole record including the raw ModR/M and SIB bytes
    check_equal("record", e, out_instr);
  endtask

  // Random instruction stream with each slot sized by the reference decode
  task automatic build_program(output logic [31:0] prog_end);
    int             pos;
    int             k;
    int             sel;
    int             n_pref;
    logic [15:0]    entry;
    logic [7:0]     modrm;
    logic [7:0]     sib;
    decoded_instr_t d;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_bytes[a] = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;
    end
    pos = START_PC;
    for (int n = 0; n < NUM_INSTR; n++) begin
      k      = pos;
      n_pref = rand_below(8);
      n_pref = (n_pref < 5) ? 0 : n_pref - 4;
      for (int p = 0; p < n_pref; p++) begin
        mem_bytes[k] = prefix_byte(rand_below(4));
        k++;
      end
      sel   = rand_below(16);
      entry = opcode_entry(sel);
      if (entry[15:8] == 8'h0F) begin
        mem_bytes[k] = 8'h0F;
        k++;
      end
      // Register number of B8+r and width bit of 88 and 8A
      if (sel == 4) entry[2:0] = 3'(rand_below(8));
      if (sel == 5 || sel == 6) entry[0] = 1'(rand_below(2));
      mem_bytes[k] = entry[7:0];
      modrm = 8'(rand_below(256));
      sel   = rand_below(4);
      // Bias toward SIB, absolute addressing and register-direct
      if (sel == 1) modrm[2:0] = 3'b100;
      if (sel == 2) modrm = {2'b00, modrm[5:3], (rand_below(2) != 0) ? 3'b101 : 3'b110};
      if (sel == 3) modrm[7:6] = 2'b11;
      sib = 8'(rand_below(256));
      if (rand_below(2) != 0) sib[2:0] = 3'b101;
      mem_bytes[k + 1] = modrm;
      mem_bytes[k + 2] = sib;
      for (int j = k + 3; j < pos + WINDOW_BYTES; j++) begin
        mem_bytes[j] = 8'(rand_below(256));
      end
      d   = expected_at(pos);
      pos = pos + (d.invalid ? 1 : int'(d.length));
    end
    prog_end = pos;
    // Little-endian words for the bus memory
    for (int w = 0; w < MEM_BYTES / 4; w++) begin
      u_mem.mem[w] = {mem_bytes[4*w+3], mem_bytes[4*w+2], mem_bytes[4*w+1], mem_bytes[4*w]};
    end
  endtask

  initial begin
    decoded_instr_t exp_rec;
    decoded_instr_t held;
    logic           holding;
    logic [31:0]    prog_end;
    logic [31:0]    exp_pc;
    int             idle;
    int             n_rec;
    go        = 1'b0;
    start_pc  = START_PC;
    out_ready = 1'b0;
    holding   = 1'b0;
    held      = '0;
    build_program(prog_end);
    idle = 0;
    while (arst_n !== 1'b1) begin
      @(negedge clk);
      idle++;
      if (idle > WAIT_LIMIT) abort_run("reset was never released");
    end
    @(negedge clk);
    go = 1'b1;
    @(negedge clk);
    go = 1'b0;
    exp_pc = START_PC;
    idle   = 0;
    n_rec  = 0;
    // Each falling edge samples the outputs and drives out_ready
    while (exp_pc < prog_end) begin
      @(negedge clk);
      if (holding) begin
        check_equal("hold_valid", 1'b1, out_valid);
        check_equal("hold_stable", held, out_instr);
      end
      // Classic read cycle on a word-aligned address
      if (wb_cyc) check_equal("wb_read", 4'b1000, {wb_stb, wb_we, wb_adr[1:0]});
      // This ready value decides the transfer on the next rising edge
      out_ready = (rand_below(3) != 0);
      if (out_valid && !out_ready) check_equal("bus_idle_on_hold", 1'b0, wb_cyc);
      if (out_valid && out_ready) begin
        exp_rec = expected_at(exp_pc);
        check_record(exp_rec);
        // Invalid bytes are skipped one at a time
        exp_pc = exp_pc + (exp_rec.invalid ? 32'd1 : 32'(exp_rec.length));
        n_rec++;
        idle = 0;
      end else begin
        idle++;
        if (idle > WAIT_LIMIT) abort_run("timeout waiting for a decoded record");
      end
      holding = out_valid && !out_ready;
      held    = out_instr;
    end
    $display("Checked %0d records", n_rec);
    if (errors == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "checks failed");
    end
  end

endmodule
